// File: Makefile
# Verilator simulation of the PIO block

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := pio_tb
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass only if the log shows the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/pio_pkg.sv
// Shared types and constants of the programmable I/O block
// Instruction encoding, machine configuration and pin-write bundle

package pio_pkg;

  localparam int N_PIN      = 32;  // Pin bank width, also X and Y width
  localparam int PROG_DEPTH = 32;  // Program words

  typedef logic [4:0]  pc_t;
  typedef logic [15:0] instr_t;

  // Opcodes in bits 15:13
  typedef enum logic [2:0] {
    OP_JMP = 3'd0,
    OP_NOP = 3'd1,  // Internal code for unsupported instructions
    OP_MOV = 3'd5,
    OP_SET = 3'd7
  } opcode_e;

  // MOV operation in op2[4:3]
  typedef enum logic [1:0] {
    MOV_NONE = 2'd0,
    MOV_INV  = 2'd1,
    MOV_REV  = 2'd2
  } mov_op_e;

  // Source and destination selectors shared by SET and MOV
  localparam logic [2:0] SEL_PINS = 3'd0;
  localparam logic [2:0] SEL_X    = 3'd1;
  localparam logic [2:0] SEL_Y    = 3'd2;
  localparam logic [2:0] SEL_NULL = 3'd3;  // MOV source only

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] delay;
    logic [2:0] op1;  // Condition or destination
    logic [4:0] op2;  // Address, data or MOV op and source
  } decoded_t;

  typedef struct packed {
    logic [15:0] div_int;    // 0 means 65536
    logic [7:0]  div_frac;
    pc_t         wrap_top;
    pc_t         wrap_target;
    logic [4:0]  jmp_pin;
    logic [4:0]  set_base;
    logic [2:0]  set_count;  // 0 to 5
    logic [4:0]  out_base;
    logic [5:0]  out_count;  // 0 to 32
  } sm_cfg_t;

  // Pins one machine writes in one cycle
  typedef struct packed {
    logic [N_PIN-1:0] mask;
    logic [N_PIN-1:0] value;
  } pin_write_t;

endpackage

// File: pio_sm/pio_clock_divider.sv
// Fractional clock divider of one state machine
// Produces the tick that lets the machine execute

`timescale 1ns/10ps

module pio_clock_divider (
  input  logic        clk,
  input  logic        reset,
  input  logic        restart,
  input  logic        enable,
  input  logic [15:0] div_int,
  input  logic [7:0]  div_frac,
  output logic        tick
);

  logic [16:0] count;      // Cycles left until the next tick
  logic [7:0]  frac_acc;
  logic [8:0]  frac_sum;   // Bit 8 is the carry
  logic [16:0] period_m1;  // Reload value after a tick

  assign frac_sum = {1'b0, frac_acc} + {1'b0, div_frac};

  // div_int of 0 stands for 65536, a carry adds one cycle
  assign period_m1 = ((div_int == 16'd0) ? 17'h0ffff : {1'b0, div_int} - 17'd1)
                     + {16'd0, frac_sum[8]};

  assign tick = enable && (count == 17'd0);

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      count    <= '0;  // First tick right after enable
      frac_acc <= '0;
    end else if (enable) begin
      if (tick) begin
        count    <= period_m1;
        frac_acc <= frac_sum[7:0];
      end else begin
        count <= count - 17'd1;
      end
    end
  end

endmodule

// File: pio_sm/pio_decoder.sv
// Instruction decoder of one state machine
// Splits the word into fields and folds unsupported forms into a no-op

`timescale 1ns/10ps

module pio_decoder
  import pio_pkg::*;
(
  input  instr_t   instr,
  output decoded_t dec
);

  logic [2:0] opcode_raw;
  logic [2:0] op1;
  logic [4:0] op2;
  logic       supported;

  assign opcode_raw = instr[15:13];
  assign op1        = instr[7:5];
  assign op2        = instr[4:0];

  always_comb begin
    case (opcode_raw)
      OP_JMP:  supported = 1'b1;  // Condition 7 simply never jumps
      OP_SET:  supported = (op1 inside {SEL_PINS, SEL_X, SEL_Y});
      OP_MOV:  supported = (op1 inside {SEL_PINS, SEL_X, SEL_Y})
                           && (op2[2:0] inside {SEL_PINS, SEL_X, SEL_Y, SEL_NULL});
      default: supported = 1'b0;
    endcase
  end

  // A no-op takes exactly one tick, so its delay is dropped
  always_comb begin
    dec.opcode = supported ? opcode_e'(opcode_raw) : OP_NOP;
    dec.delay  = supported ? instr[12:8] : 5'd0;
    dec.op1    = op1;
    dec.op2    = op2;
  end

endmodule

// File: pio_sm/pio_sm.sv
// One PIO state machine with PC and wrap, X, Y and delay counter
// Executes JMP, SET and MOV and registers its pin write for the merger

`timescale 1ns/10ps

module pio_sm
  import pio_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             restart,
  input  logic             enable,
  input  sm_cfg_t          cfg,
  input  instr_t           instr,
  input  logic [N_PIN-1:0] input_pins,
  output pc_t              pc,
  output pin_write_t       pin_write
);

  logic             tick;
  logic             exec;       // Tick with no delay pending
  decoded_t         dec;
  logic [4:0]       delay_cnt;
  logic [N_PIN-1:0] x;
  logic [N_PIN-1:0] y;
  logic             jmp_taken;
  logic             dec_x;
  logic             dec_y;
  pc_t              pc_seq;
  logic [N_PIN-1:0] mov_src;
  logic [N_PIN-1:0] mov_val;
  logic [N_PIN-1:0] src_val;    // Data for SET or MOV
  logic             pins_wr;
  logic [4:0]       pins_base;
  logic [5:0]       pins_count;
  logic [N_PIN-1:0] wr_mask;
  logic [N_PIN-1:0] wr_value;

  function automatic logic [N_PIN-1:0] rotl(input logic [N_PIN-1:0] v, input logic [4:0] sh);
    logic [2*N_PIN-1:0] d;
    d = {v, v} << sh;
    return d[2*N_PIN-1:N_PIN];
  endfunction

  function automatic logic [N_PIN-1:0] low_mask(input logic [5:0] n);
    return (n >= N_PIN) ? '1 : ((N_PIN'(1) << n) - N_PIN'(1));
  endfunction

  function automatic logic [N_PIN-1:0] bit_reverse(input logic [N_PIN-1:0] v);
    logic [N_PIN-1:0] r;
    for (int i = 0; i < N_PIN; i++) begin
      r[i] = v[N_PIN-1-i];
    end
    return r;
  endfunction

  pio_clock_divider clock_divider_i (
    .clk      (clk),
    .reset    (reset),
    .restart  (restart),
    .enable   (enable),
    .div_int  (cfg.div_int),
    .div_frac (cfg.div_frac),
    .tick     (tick)
  );

  pio_decoder decoder_i (
    .instr (instr),
    .dec   (dec)
  );

  assign exec   = tick && (delay_cnt == 5'd0);
  assign pc_seq = (pc == cfg.wrap_top) ? cfg.wrap_target : pc + pc_t'(1);

  // JMP conditions, decrement only when nonzero
  always_comb begin
    jmp_taken = 1'b0;
    dec_x     = 1'b0;
    dec_y     = 1'b0;
    case (dec.op1)
      3'd0: jmp_taken = 1'b1;
      3'd1: jmp_taken = (x == '0);
      3'd2: begin
        jmp_taken = (x != '0);
        dec_x     = jmp_taken;
      end
      3'd3: jmp_taken = (y == '0);
      3'd4: begin
        jmp_taken = (y != '0);
        dec_y     = jmp_taken;
      end
      3'd5: jmp_taken = (x != y);
      3'd6: jmp_taken = input_pins[cfg.jmp_pin];
      default: jmp_taken = 1'b0;
    endcase
  end

  // MOV operand
  always_comb begin
    case (dec.op2[2:0])
      SEL_PINS: mov_src = input_pins;  // No input rotation
      SEL_X:    mov_src = x;
      SEL_Y:    mov_src = y;
      default:  mov_src = '0;
    endcase
    case (mov_op_e'(dec.op2[4:3]))
      MOV_INV: mov_val = ~mov_src;
      MOV_REV: mov_val = bit_reverse(mov_src);
      default: mov_val = mov_src;  // Code 3 is reserved
    endcase
  end

  assign src_val = (dec.opcode == OP_SET) ? N_PIN'(dec.op2) : mov_val;

  // SET uses the set window, MOV the out window
  always_comb begin
    pins_wr    = 1'b0;
    pins_base  = cfg.out_base;
    pins_count = cfg.out_count;
    if (dec.op1 == SEL_PINS) begin
      if (dec.opcode == OP_SET) begin
        pins_wr    = 1'b1;
        pins_base  = cfg.set_base;
        pins_count = (cfg.set_count > 3'd5) ? 6'd5 : {3'b0, cfg.set_count};
      end else if (dec.opcode == OP_MOV) begin
        pins_wr = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      pc        <= '0;
      x         <= '0;
      y         <= '0;
      delay_cnt <= '0;
    end else begin
      if (tick && (delay_cnt != 5'd0)) begin
        delay_cnt <= delay_cnt - 5'd1;  // Idle tick
      end
      if (exec) begin
        delay_cnt <= dec.delay;
        pc        <= pc_seq;
        case (dec.opcode)
          OP_JMP: begin
            if (jmp_taken) begin
              pc <= dec.op2;
            end
            if (dec_x) begin
              x <= x - N_PIN'(1);
            end
            if (dec_y) begin
              y <= y - N_PIN'(1);
            end
          end
          OP_SET, OP_MOV: begin
            if (dec.op1 == SEL_X) begin
              x <= src_val;
            end
            if (dec.op1 == SEL_Y) begin
              y <= src_val;
            end
          end
          default: ;  // No-op only advances the PC
        endcase
      end
    end
  end

  // Mask is a single-cycle pulse after the executing edge
  always_ff @(posedge clk) begin
    if (reset || restart) begin
      wr_mask <= '0;
    end else begin
      wr_mask <= (exec && pins_wr) ? rotl(low_mask(pins_count), pins_base) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (exec && pins_wr) begin
      wr_value <= rotl(src_val & low_mask(pins_count), pins_base);  // Wraps modulo 32
    end
  end

  assign pin_write = '{mask: wr_mask, value: wr_value};

endmodule

// File: src/pio_pin_merge.sv
// Pin merger holding the output pin bank
// Highest-indexed writer wins per pin, strobe marks every written pin

`timescale 1ns/10ps

module pio_pin_merge
  import pio_pkg::*;
#(
  parameter int N_SM = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  pin_write_t       pin_write [N_SM],
  output logic [N_PIN-1:0] output_pins,
  output logic [N_PIN-1:0] output_pins_stb
);

  logic [N_PIN-1:0] next_pins;
  logic [N_PIN-1:0] written;

  // Later machines overwrite earlier ones
  always_comb begin
    next_pins = output_pins;
    written   = '0;
    for (int s = 0; s < N_SM; s++) begin
      next_pins = (next_pins & ~pin_write[s].mask)
                  | (pin_write[s].value & pin_write[s].mask);
      written   = written | pin_write[s].mask;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins     <= '0;
      output_pins_stb <= '0;
    end else begin
      output_pins     <= next_pins;
      output_pins_stb <= written;  // One cycle per write
    end
  end

endmodule

// File: src/pio_program_mem.sv
// Shared program store of all state machines
// One synchronous write port, one asynchronous read port per machine

`timescale 1ns/10ps

module pio_program_mem
  import pio_pkg::*;
#(
  parameter int N_SM = 4
) (
  input  logic   clk,
  input  logic   prog_wr,
  input  pc_t    prog_addr,
  input  instr_t prog_data,
  input  pc_t    pc    [N_SM],
  output instr_t instr [N_SM]
);

  instr_t mem [PROG_DEPTH];  // Register array, no reset

  // Loaded only while the machines are stopped
  always_ff @(posedge clk) begin
    if (prog_wr) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // Each machine sees its own word in the same cycle
  always_comb begin
    for (int i = 0; i < N_SM; i++) begin
      instr[i] = mem[pc[i]];
    end
  end

endmodule

// File: src/pio_top.sv
// Top level of the programmable I/O block
// Program memory feeding N_SM state machines, which drive the pin merger

`timescale 1ns/10ps

module pio_top
  import pio_pkg::*;
#(
  parameter int N_SM = 4  // 1 to 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [N_SM-1:0]  sm_enable,
  input  logic [N_SM-1:0]  sm_restart,
  input  sm_cfg_t          sm_cfg [N_SM],
  input  logic             prog_wr,
  input  pc_t              prog_addr,
  input  instr_t           prog_data,
  input  logic [N_PIN-1:0] input_pins,
  output logic [N_PIN-1:0] output_pins,
  output logic [N_PIN-1:0] output_pins_stb
);

  pc_t        sm_pc        [N_SM];
  instr_t     sm_instr     [N_SM];
  pin_write_t sm_pin_write [N_SM];

  pio_program_mem #(
    .N_SM (N_SM)
  ) program_mem_i (
    .clk       (clk),
    .prog_wr   (prog_wr),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (sm_pc),
    .instr     (sm_instr)
  );

  for (genvar g = 0; g < N_SM; g++) begin : g_sm
    pio_sm sm_i (
      .clk        (clk),
      .reset      (reset),
      .restart    (sm_restart[g]),
      .enable     (sm_enable[g]),
      .cfg        (sm_cfg[g]),
      .instr      (sm_instr[g]),
      .input_pins (input_pins),
      .pc         (sm_pc[g]),
      .pin_write  (sm_pin_write[g])
    );
  end

  pio_pin_merge #(
    .N_SM (N_SM)
  ) pin_merge_i (
    .clk             (clk),
    .reset           (reset),
    .pin_write       (sm_pin_write),
    .output_pins     (output_pins),
    .output_pins_stb (output_pins_stb)
  );

endmodule

// File: tests/pio_checker.sv
// Concurrent checks on the pin merger outputs
// Strobe after reset, pin changes against strobes, strobes against write masks

`timescale 1ns/10ps

module pio_checker
  import pio_pkg::*;
#(
  parameter int N_SM = 4
) (
  input logic             clk,
  input logic             reset,
  input pin_write_t       pin_write [N_SM],
  input logic [N_PIN-1:0] output_pins,
  input logic [N_PIN-1:0] output_pins_stb
);

  int unsigned      error_count = 0;
  logic [N_PIN-1:0] any_mask;  // Pins written by any machine

  always_comb begin
    any_mask = '0;
    for (int s = 0; s < N_SM; s++) begin
      any_mask = any_mask | pin_write[s].mask;
    end
  end

  stb_clear_after_reset: assert property (@(posedge clk) reset |=> output_pins_stb == '0)
    else begin
      error_count++;
      $error("pin strobe set in the cycle after reset");
    end

  pins_change_with_stb: assert property (@(posedge clk) disable iff (reset)
      ((output_pins ^ $past(output_pins)) & ~output_pins_stb) == '0)
    else begin
      error_count++;
      $error("output pin changed without its strobe");
    end

  stb_needs_mask: assert property (@(posedge clk) disable iff (reset)
      (output_pins_stb & ~$past(any_mask)) == '0)
    else begin
      error_count++;
      $error("pin strobe without a write mask in the previous cycle");
    end

endmodule

bind pio_pin_merge pio_checker #(.N_SM(N_SM)) checker_i (
  .clk             (clk),
  .reset           (reset),
  .pin_write       (pin_write),
  .output_pins     (output_pins),
  .output_pins_stb (output_pins_stb)
);

// File: tests/pio_tb.sv
// Testbench of the programmable I/O block
// Random programs on the state machines, checked against a model of pc, X, Y and pins

`timescale 1ns/10ps

module pio_tb;
  import pio_pkg::*;

  localparam int N_SM     = 4;
  localparam int MAX_WAIT = 2000;  // Cycles per strobe wait

  logic             clk;
  logic             reset;
  logic [N_SM-1:0]  sm_enable;
  logic [N_SM-1:0]  sm_restart;
  sm_cfg_t          sm_cfg [N_SM];
  logic             prog_wr;
  pc_t              prog_addr;
  instr_t           prog_data;
  logic [N_PIN-1:0] input_pins;
  logic [N_PIN-1:0] output_pins;
  logic [N_PIN-1:0] output_pins_stb;

  // Model state
  instr_t      prog    [PROG_DEPTH];
  sm_cfg_t     cfg_set [N_SM];
  logic [31:0] pins_set;
  pc_t         m_pc    [N_SM];
  logic [31:0] m_x     [N_SM];
  logic [31:0] m_y     [N_SM];
  logic [31:0] m_pins;
  logic [31:0] rng = 32'h11b7_9336;

  pio_top #(
    .N_SM (N_SM)
  ) pio_top_i (
    .clk             (clk),
    .reset           (reset),
    .sm_enable       (sm_enable),
    .sm_restart      (sm_restart),
    .sm_cfg          (sm_cfg),
    .prog_wr         (prog_wr),
    .prog_addr       (prog_addr),
    .prog_data       (prog_data),
    .input_pins      (input_pins),
    .output_pins     (output_pins),
    .output_pins_stb (output_pins_stb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(next_rand() % 32'(hi - lo + 1));
  endfunction

  function automatic instr_t enc(input logic [2:0] op, input logic [4:0] delay,
                                 input logic [2:0] op1, input logic [4:0] op2);
    return {op, delay, op1, op2};
  endfunction

  function automatic sm_cfg_t plain_cfg();
    sm_cfg_t c;
    c           = '0;
    c.div_int   = 16'd1;
    c.wrap_top  = 5'd31;
    c.set_count = 3'd5;
    c.out_count = 6'd32;
    return c;
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  // One instruction of machine s, returns the pins it writes
  function automatic void model_exec(input int s, output logic [31:0] mask,
                                     output logic [31:0] value);
    logic [2:0]  op;
    logic [2:0]  op1;
    logic [4:0]  op2;
    logic [31:0] data;
    logic [31:0] src;
    logic        taken;
    logic        has_data;
    int          base;
    int          count;
    pc_t         seq;
    op       = prog[m_pc[s]][15:13];
    op1      = prog[m_pc[s]][7:5];
    op2      = prog[m_pc[s]][4:0];
    mask     = '0;
    value    = '0;
    data     = '0;
    src      = '0;
    base     = 0;
    count    = 0;
    taken    = 1'b0;
    has_data = 1'b0;
    seq      = (m_pc[s] == cfg_set[s].wrap_top) ? cfg_set[s].wrap_target : m_pc[s] + 5'd1;
    if (op == 3'd0) begin
      case (op1)
        3'd0: taken = 1'b1;
        3'd1: taken = (m_x[s] == 32'd0);
        3'd2: taken = (m_x[s] != 32'd0);
        3'd3: taken = (m_y[s] == 32'd0);
        3'd4: taken = (m_y[s] != 32'd0);
        3'd5: taken = (m_x[s] != m_y[s]);
        3'd6: taken = pins_set[cfg_set[s].jmp_pin];
        default: taken = 1'b0;
      endcase
      if (taken && (op1 == 3'd2)) begin
        m_x[s] = m_x[s] - 32'd1;  // Post-decrement
      end
      if (taken && (op1 == 3'd4)) begin
        m_y[s] = m_y[s] - 32'd1;
      end
    end else if ((op == 3'd7) && (op1 <= 3'd2)) begin
      has_data = 1'b1;
      data     = 32'(op2);
      base     = int'(cfg_set[s].set_base);
      count    = (cfg_set[s].set_count > 3'd5) ? 5 : int'(cfg_set[s].set_count);
    end else if ((op == 3'd5) && (op1 <= 3'd2) && (op2[2:0] <= 3'd3)) begin
      case (op2[2:0])
        3'd0: src = pins_set;
        3'd1: src = m_x[s];
        3'd2: src = m_y[s];
        default: src = '0;
      endcase
      data = src;
      if (op2[4:3] == 2'd1) begin
        data = ~src;
      end
      if (op2[4:3] == 2'd2) begin
        for (int i = 0; i < 32; i++) begin
          data[i] = src[31-i];
        end
      end
      has_data = 1'b1;
      base     = int'(cfg_set[s].out_base);
      count    = (cfg_set[s].out_count > 6'd32) ? 32 : int'(cfg_set[s].out_count);
    end
    if (has_data && (op1 == 3'd0)) begin
      for (int i = 0; i < count; i++) begin
        mask[(base + i) % 32]  = 1'b1;  // Window wraps around the bank
        value[(base + i) % 32] = data[i];
      end
    end else if (has_data && (op1 == 3'd1)) begin
      m_x[s] = data;
    end else if (has_data && (op1 == 3'd2)) begin
      m_y[s] = data;
    end
    m_pc[s] = taken ? op2 : seq;
  endfunction

  task automatic wait_strobe(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > MAX_WAIT) begin
        $display("Timeout: the pin strobe for %s never came", name);
        stop_on_error();
      end
    end while (output_pins_stb == '0);
  endtask

  // Machines lo..hi run in step, the highest index wins per pin
  task automatic next_write(input string name, input int lo, input int hi,
                            output int cycles);
    logic [31:0] mask;
    logic [31:0] value;
    logic [31:0] union_mask;
    int          steps;
    union_mask = '0;
    steps      = 0;
    while (union_mask == '0) begin
      for (int s = lo; s <= hi; s++) begin
        model_exec(s, mask, value);
        m_pins     = (m_pins & ~mask) | (value & mask);
        union_mask = union_mask | mask;
      end
      steps++;
      if (steps > 64) begin
        $display("Model of %s ran 64 instructions without a pin write", name);
        stop_on_error();
      end
    end
    wait_strobe(name, cycles);
    check({name, " strobe"}, union_mask, output_pins_stb);
    check({name, " pins"}, m_pins, output_pins);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    reset      <= 1'b1;
    sm_enable  <= '0;
    sm_restart <= '0;
    prog_wr    <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    m_pins   = '0;
    pins_set = '0;
    for (int s = 0; s < N_SM; s++) begin
      m_pc[s]    = '0;
      m_x[s]     = '0;
      m_y[s]     = '0;
      cfg_set[s] = plain_cfg();
    end
    for (int a = 0; a < PROG_DEPTH; a++) begin
      prog[a] = enc(3'd1, 5'd0, 3'd0, 5'(a));  // Unused words are no-ops
    end
  endtask

  task automatic write_program();
    for (int a = 0; a < PROG_DEPTH; a++) begin
      @(posedge clk);
      prog_wr   <= 1'b1;
      prog_addr <= pc_t'(a);
      prog_data <= prog[a];
    end
    @(posedge clk);
    prog_wr <= 1'b0;
  endtask

  // Config one edge ahead of the enable
  task automatic setup_and_start(input logic [N_SM-1:0] en);
    write_program();
    @(posedge clk);
    for (int s = 0; s < N_SM; s++) begin
      sm_cfg[s] <= cfg_set[s];
    end
    input_pins <= pins_set;
    @(posedge clk);
    sm_enable <= en;
  endtask

  task automatic test_set_mov();
    int         cycles;
    logic [2:0] dest;
    reset_dut();
    cfg_set[0].div_int   = 16'(rand_range(1, 3));
    cfg_set[0].set_base  = 5'(next_rand());
    cfg_set[0].set_count = 3'(rand_range(1, 5));
    cfg_set[0].out_base  = 5'(next_rand());
    cfg_set[0].out_count = 6'(rand_range(1, 32));
    cfg_set[0].wrap_top  = 5'd7;
    pins_set = next_rand();
    for (int a = 0; a < 8; a++) begin
      dest = ((a == 0) || (a == 4)) ? SEL_PINS : 3'(rand_range(0, 2));
      if ((a == 0) || ((a != 4) && (rand_range(0, 1) == 1))) begin
        prog[a] = enc(OP_SET, 5'(rand_range(0, 3)), dest, 5'(next_rand()));
      end else begin
        prog[a] = enc(OP_MOV, 5'(rand_range(0, 3)), dest,
                      {2'(rand_range(0, 2)), 3'(rand_range(0, 3))});
      end
    end
    setup_and_start(N_SM'(1));
    repeat (12) next_write("set_mov", 0, 0, cycles);
  endtask

  task automatic test_jmp();
    int cycles;
    for (int cond = 0; cond < 8; cond++) begin
      reset_dut();
      cfg_set[0].div_int   = 16'(rand_range(1, 2));
      cfg_set[0].set_base  = 5'(next_rand());
      cfg_set[0].set_count = 3'd2;
      cfg_set[0].jmp_pin   = 5'(next_rand());
      pins_set = next_rand();
      prog[0] = enc(OP_SET, 5'd0, SEL_X, 5'(rand_range(0, 3)));
      prog[1] = enc(OP_SET, 5'd0, SEL_Y, 5'(rand_range(0, 3)));
      prog[2] = enc(OP_SET, 5'd0, SEL_PINS, 5'd1);  // Start marker
      prog[3] = enc(OP_JMP, 5'd0, 3'(cond), 5'd6);
      prog[4] = enc(OP_SET, 5'd0, SEL_PINS, 5'd2);  // Not taken
      prog[5] = enc(OP_JMP, 5'd0, 3'd0, 5'd0);
      prog[6] = enc(OP_SET, 5'd0, SEL_PINS, 5'd3);  // Taken
      prog[7] = enc(OP_JMP, 5'd0, 3'd0, 5'd3);
      setup_and_start(N_SM'(1));
      repeat (12) next_write($sformatf("jmp cond %0d", cond), 0, 0, cycles);
    end
  endtask

  task automatic test_wrap();
    int cycles;
    reset_dut();
    cfg_set[0].set_base    = 5'(next_rand());
    cfg_set[0].set_count   = 3'd3;
    cfg_set[0].wrap_target = 5'(rand_range(1, 3));
    cfg_set[0].wrap_top    = 5'(rand_range(4, 6));
    for (int a = 0; a < 8; a++) begin
      prog[a] = enc(OP_SET, 5'd0, SEL_PINS, 5'(a));
    end
    setup_and_start(N_SM'(1));
    repeat (16) next_write("wrap", 0, 0, cycles);
  endtask

  task automatic test_timing(input logic with_frac);
    int cycles;
    int d1;
    int d2;
    int dv;
    int f;
    int n;
    int acc;
    int spacing;
    reset_dut();
    d1 = rand_range(0, 7);
    d2 = rand_range(0, 7);
    dv = rand_range(1, 6);
    f  = with_frac ? rand_range(1, 255) : 0;
    cfg_set[0].div_int   = 16'(dv);
    cfg_set[0].div_frac  = 8'(f);
    cfg_set[0].set_count = 3'd2;
    cfg_set[0].wrap_top  = 5'd1;
    prog[0] = enc(OP_SET, 5'(d1), SEL_PINS, 5'd1);
    prog[1] = enc(OP_SET, 5'(d2), SEL_PINS, 5'd2);
    setup_and_start(N_SM'(1));
    next_write("timing first", 0, 0, cycles);
    acc = 0;  // Fraction accumulator, cleared by reset
    for (int k = 1; k < 9; k++) begin
      n = ((k % 2) == 1) ? 1 + d1 : 1 + d2;  // Ticks spent on the previous word
      spacing = 0;
      for (int t = 0; t < n; t++) begin
        spacing = spacing + dv + ((acc + f) / 256);  // Carry stretches the following period
        acc     = (acc + f) % 256;
      end
      next_write("timing", 0, 0, cycles);
      check($sformatf("timing spacing div %0d frac %0d", dv, f),
            32'(spacing), 32'(cycles));
    end
  endtask

  task automatic test_multi();
    int cycles;
    int dv;
    reset_dut();
    dv = rand_range(1, 3);
    for (int s = 0; s < N_SM; s++) begin
      cfg_set[s].div_int   = 16'(dv);  // Same timing keeps the machines in step
      cfg_set[s].set_base  = 5'(next_rand());
      cfg_set[s].set_count = 3'(rand_range(1, 5));
      cfg_set[s].wrap_top  = 5'd5;
    end
    for (int a = 0; a < 6; a++) begin
      prog[a] = enc(OP_SET, 5'(rand_range(0, 2)), SEL_PINS, 5'(next_rand()));
    end
    setup_and_start('1);
    repeat (12) next_write("multi", 0, N_SM - 1, cycles);
  endtask

  task automatic test_restart();
    int cycles;
    int s;
    reset_dut();
    s = rand_range(0, N_SM - 1);
    cfg_set[s].div_int   = 16'd1;  // One instruction per cycle
    cfg_set[s].out_base  = 5'(next_rand());
    cfg_set[s].out_count = 6'(rand_range(1, 32));
    prog[0] = enc(OP_MOV, 5'd0, SEL_PINS, {2'd0, SEL_X});
    prog[1] = enc(OP_MOV, 5'd0, SEL_PINS, {2'd1, SEL_Y});  // Inverted Y
    prog[2] = enc(OP_SET, 5'd0, SEL_X, 5'(rand_range(1, 31)));
    prog[3] = enc(OP_SET, 5'd0, SEL_Y, 5'(rand_range(1, 31)));
    prog[4] = enc(OP_MOV, 5'd0, SEL_PINS, {2'd2, SEL_X});  // Reversed X
    prog[5] = enc(OP_JMP, 5'd0, 3'd0, 5'd5);                // Halt
    setup_and_start(N_SM'(1) << s);
    repeat (2) next_write("restart first run", s, s, cycles);
    @(posedge clk);                 // Word 3 executes here
    sm_restart <= N_SM'(1) << s;    // Lands on the edge of the word 4 pin write
    @(posedge clk);
    sm_enable  <= '0;
    sm_restart <= '0;
    m_pc[s] = '0;
    m_x[s]  = '0;
    m_y[s]  = '0;
    repeat (4) begin
      @(negedge clk);
      check("restart keeps pins", m_pins, output_pins);
      check("restart no strobe", 32'd0, output_pins_stb);
    end
    @(posedge clk);
    sm_enable <= N_SM'(1) << s;
    repeat (3) next_write("restart second run", s, s, cycles);
  endtask

  initial begin
    reset      <= 1'b1;
    sm_enable  <= '0;
    sm_restart <= '0;
    prog_wr    <= 1'b0;
    prog_addr  <= '0;
    prog_data  <= '0;
    input_pins <= '0;
    for (int s = 0; s < N_SM; s++) begin
      sm_cfg[s] <= '0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_set_mov();
    test_jmp();
    test_wrap();
    test_timing(1'b0);
    test_timing(1'b1);
    test_multi();
    test_restart();
    repeat (4) @(posedge clk);
    if (pio_top_i.pin_merge_i.checker_i.error_count != 0) begin
      $display("Pin merger assertions failed %0d times",
               pio_top_i.pin_merge_i.checker_i.error_count);
      stop_on_error();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: vlog.f
common/pio_pkg.sv
src/pio_program_mem.sv
pio_sm/pio_clock_divider.sv
pio_sm/pio_decoder.sv
pio_sm/pio_sm.sv
src/pio_pin_merge.sv
src/pio_top.sv
tests/pio_checker.sv
tests/pio_tb.sv
